// File: vliwIsaPkg.sv
package vliwIsaPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int slotCount = 3;

    // codes not listed here behave as nop in every slot
    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        SLL   = 6'd6,
        ADDI  = 6'd7,
        LUI   = 6'd8,
        OUT   = 6'd9,
        LOAD  = 6'd10,
        STORE = 6'd11
    } opcode_e;

    // 16-bit immediate is {rd, immLow}
    typedef struct packed {
        opcode_e                 opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [10:0]             immLow;
    } instr_t;

    // slot 0 in the lowest word
    typedef instr_t [slotCount-1:0] bundle_t;

    typedef struct packed {
        logic                    start;
        opcode_e                 opcode;
        logic [dataWidth-1:0]    rsValue;
        logic [dataWidth-1:0]    rtValue;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    imm;
    } slotCmd_t;

    typedef struct packed {
        logic                    done;
        logic                    writeEnable;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    data;
    } slotResult_t;

endpackage

// File: vliwBusPkg.sv
package vliwBusPkg;

    localparam int busWidth = 32;

    // word address, upper bits zero beyond the memory size
    typedef struct packed {
        logic                valid;
        logic                write;
        logic [busWidth-1:0] addr;
        logic [busWidth-1:0] wdata;
    } memReq_t;

    // valid pulses once per request, for stores too
    typedef struct packed {
        logic                valid;
        logic [busWidth-1:0] rdata;
    } memRsp_t;

endpackage

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int memAddrWidth = 8
) (
    input  logic                clk,
    input  vliwBusPkg::memReq_t req,
    output vliwBusPkg::memRsp_t rsp
);
    import vliwBusPkg::*;

    logic [busWidth-1:0]     mem [2**memAddrWidth];
    logic [memAddrWidth-1:0] index;

    assign index = req.addr[memAddrWidth-1:0];

    // read before write, stores get the old word back
    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            mem[index] <= req.wdata;
        end
        rsp.valid <= req.valid;
        rsp.rdata <= mem[index];
    end

endmodule

// File: memArbiter.sv
`timescale 1ns/1ps

module memArbiter #(
    parameter int memAddrWidth = 8
) (
    input  logic                clk,
    input  logic                rstn,
    input  vliwBusPkg::memReq_t req0,
    output vliwBusPkg::memRsp_t rsp0,
    input  vliwBusPkg::memReq_t req1,
    output vliwBusPkg::memRsp_t rsp1,
    output vliwBusPkg::memReq_t memReq,
    input  vliwBusPkg::memRsp_t memRsp
);
    logic busy;
    logic owner;
    logic pick;

    // req0 wins whenever it asks
    assign pick = !req0.valid;

    always_comb begin
        memReq = pick ? req1 : req0;
        memReq.valid = !busy && (req0.valid || req1.valid);
        rsp0.valid = busy && !owner && memRsp.valid;
        rsp0.rdata = memRsp.rdata;
        rsp1.valid = busy && owner && memRsp.valid;
        rsp1.rdata = memRsp.rdata;
    end

    // grant held until the memory answers
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            owner <= 1'b0;
        end else if (!busy && (req0.valid || req1.valid)) begin
            busy <= 1'b1;
            owner <= pick;
        end else if (busy && memRsp.valid) begin
            busy <= 1'b0;
        end
    end

    // every memory answer goes to exactly one slot
    oneRspRouted: assert property (
        @(posedge clk) disable iff (!rstn)
        $countones({rsp0.valid, rsp1.valid}) == int'(memRsp.valid)
    );

    // slots hand over addresses already cut to the memory size
    addrInRange: assert property (
        @(posedge clk) disable iff (!rstn)
        memReq.valid |-> (memReq.addr >> memAddrWidth) == '0
    );

endmodule

// File: memSlot.sv
`timescale 1ns/1ps

module memSlot #(
    parameter int memAddrWidth = 8
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  vliwIsaPkg::slotCmd_t    cmd,
    output vliwIsaPkg::slotResult_t result,
    output vliwBusPkg::memReq_t     memReq,
    input  vliwBusPkg::memRsp_t     memRsp,
    input  logic                    commit
);
    import vliwIsaPkg::*;
    import vliwBusPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } state_e;

    state_e                  state;
    logic                    writeEnable;
    logic [regAddrWidth-1:0] dest;
    logic [dataWidth-1:0]    data;
    logic                    reqWrite;
    logic [busWidth-1:0]     reqAddr;
    logic [busWidth-1:0]     reqWdata;
    logic [dataWidth-1:0]    effAddr;

    assign effAddr = cmd.rsValue + cmd.imm;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            writeEnable <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd.start) begin
                        writeEnable <= (cmd.opcode == LOAD);
                        state <= (cmd.opcode inside {LOAD, STORE}) ? ACCESS : DONE;
                    end
                end
                ACCESS: begin
                    if (memRsp.valid) begin
                        state <= DONE;
                    end
                end
                default: begin
                    if (commit) begin
                        state <= IDLE;
                        writeEnable <= 1'b0;
                    end
                end
            endcase
        end
    end

    // address wraps to the memory size
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            dest <= cmd.dest;
            reqWrite <= (cmd.opcode == STORE);
            reqAddr <= busWidth'(effAddr[memAddrWidth-1:0]);
            reqWdata <= cmd.rtValue;
        end
        if (state == ACCESS && memRsp.valid) begin
            data <= memRsp.rdata;
        end
    end

    always_comb begin
        memReq.valid = (state == ACCESS);
        memReq.write = reqWrite;
        memReq.addr = reqAddr;
        memReq.wdata = reqWdata;
        result.done = (state == DONE);
        result.writeEnable = writeEnable;
        result.dest = dest;
        result.data = data;
    end

endmodule

// File: aluSlot.sv
`timescale 1ns/1ps

module aluSlot (
    input  logic                             clk,
    input  logic                             rstn,
    input  vliwIsaPkg::slotCmd_t             cmd,
    output vliwIsaPkg::slotResult_t          result,
    output logic                             outValid,
    input  logic                             outReady,
    output logic [vliwIsaPkg::dataWidth-1:0] outData,
    input  logic                             commit
);
    import vliwIsaPkg::*;

    logic                    done;
    logic                    writeEnable;
    logic [regAddrWidth-1:0] dest;
    logic [dataWidth-1:0]    data;
    logic [dataWidth-1:0]    aluValue;
    logic                    writesReg;

    always_comb begin
        aluValue = '0;
        writesReg = 1'b1;
        case (cmd.opcode)
            ADD:     aluValue = cmd.rsValue + cmd.rtValue;
            SUB:     aluValue = cmd.rsValue - cmd.rtValue;
            AND:     aluValue = cmd.rsValue & cmd.rtValue;
            OR:      aluValue = cmd.rsValue | cmd.rtValue;
            XOR:     aluValue = cmd.rsValue ^ cmd.rtValue;
            SLL:     aluValue = cmd.rsValue << cmd.rtValue[4:0];
            ADDI:    aluValue = cmd.rsValue + cmd.imm;
            LUI:     aluValue = {cmd.imm[15:0], 16'h0000};
            default: writesReg = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
            writeEnable <= 1'b0;
            outValid <= 1'b0;
        end else if (cmd.start) begin
            if (cmd.opcode == OUT) begin
                outValid <= 1'b1;
                writeEnable <= 1'b0;
            end else begin
                done <= 1'b1;
                writeEnable <= writesReg;
            end
        end else if (outValid && outReady) begin
            // out finishes one cycle after the handshake
            outValid <= 1'b0;
            done <= 1'b1;
        end else if (commit) begin
            done <= 1'b0;
            writeEnable <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            dest <= cmd.dest;
            data <= aluValue;
            if (cmd.opcode == OUT) begin
                outData <= cmd.rsValue;
            end
        end
    end

    always_comb begin
        result.done = done;
        result.writeEnable = writeEnable;
        result.dest = dest;
        result.data = data;
    end

    outHoldsUnderStall: assert property (
        @(posedge clk) disable iff (!rstn)
        outValid && !outReady |=> outValid && $stable(outData)
    );

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [2*vliwIsaPkg::slotCount-1:0][vliwIsaPkg::regAddrWidth-1:0] readIndex,
    output logic [2*vliwIsaPkg::slotCount-1:0][vliwIsaPkg::dataWidth-1:0]    readData,
    input  vliwIsaPkg::slotResult_t [vliwIsaPkg::slotCount-1:0] results,
    input  logic                                   commit
);
    import vliwIsaPkg::*;

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    // r0 reads as zero whatever was written
    always_comb begin
        for (int k = 0; k < 2*slotCount; k++) begin
            readData[k] = (readIndex[k] == '0) ? '0 : regs[readIndex[k]];
        end
    end

    // later slots overwrite earlier ones
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int r = 0; r < 2**regAddrWidth; r++) begin
                regs[r] <= '0;
            end
        end else if (commit) begin
            for (int i = 0; i < slotCount; i++) begin
                if (results[i].writeEnable) begin
                    regs[results[i].dest] <= results[i].data;
                end
            end
        end
    end

endmodule

// File: bundleIssue.sv
`timescale 1ns/1ps

module bundleIssue (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   bundleValid,
    output logic                                   bundleReady,
    input  vliwIsaPkg::bundle_t                    bundle,
    output logic [2*vliwIsaPkg::slotCount-1:0][vliwIsaPkg::regAddrWidth-1:0] readIndex,
    input  logic [2*vliwIsaPkg::slotCount-1:0][vliwIsaPkg::dataWidth-1:0]    readData,
    output vliwIsaPkg::slotCmd_t [vliwIsaPkg::slotCount-1:0] slotCmd,
    input  logic [vliwIsaPkg::slotCount-1:0]       slotDone,
    output logic                                   commit
);
    import vliwIsaPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        COMMIT
    } state_e;

    state_e                                state;
    logic                                  start;
    logic                                  accept;
    bundle_t                               bundleReg;
    logic [2*slotCount-1:0][dataWidth-1:0] operands;

    assign bundleReady = (state == IDLE);
    assign accept = bundleValid && bundleReady;
    assign commit = (state == COMMIT);

    // rs on even ports, rt on odd ports
    always_comb begin
        for (int i = 0; i < slotCount; i++) begin
            readIndex[2*i] = bundle[i].rs;
            readIndex[2*i+1] = bundle[i].rt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= EXEC;
                        start <= 1'b1;
                    end
                end
                EXEC: begin
                    if (&slotDone) begin
                        state <= COMMIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operands frozen at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            bundleReg <= bundle;
            operands <= readData;
        end
    end

    always_comb begin
        for (int i = 0; i < slotCount; i++) begin
            slotCmd[i].start = start;
            slotCmd[i].opcode = bundleReg[i].opcode;
            slotCmd[i].rsValue = operands[2*i];
            slotCmd[i].rtValue = operands[2*i+1];
            slotCmd[i].imm = {{16{bundleReg[i].rd[4]}}, bundleReg[i].rd, bundleReg[i].immLow};
            case (bundleReg[i].opcode)
                ADD, SUB, AND, OR, XOR, SLL: slotCmd[i].dest = bundleReg[i].rd;
                ADDI, LUI, LOAD:             slotCmd[i].dest = bundleReg[i].rt;
                default:                     slotCmd[i].dest = '0;
            endcase
        end
    end

    // every slot must have finished before results are written
    commitNeedsDone: assert property (
        @(posedge clk) disable iff (!rstn) commit |-> &slotDone
    );

endmodule

// File: vliwCore.sv
`timescale 1ns/1ps

module vliwCore #(
    parameter int memAddrWidth = 8
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              bundleValid,
    output logic                              bundleReady,
    input  vliwIsaPkg::bundle_t               bundle,
    output logic                              outValid,
    input  logic                              outReady,
    output logic [vliwIsaPkg::dataWidth-1:0]  outData
);
    import vliwIsaPkg::*;
    import vliwBusPkg::*;

    logic [2*slotCount-1:0][regAddrWidth-1:0] readIndex;
    logic [2*slotCount-1:0][dataWidth-1:0]    readData;
    slotCmd_t    [slotCount-1:0]              slotCmd;
    slotResult_t [slotCount-1:0]              results;
    logic                                     commit;

    memReq_t slot1Req;
    memReq_t slot2Req;
    memReq_t memReq;
    memRsp_t slot1Rsp;
    memRsp_t slot2Rsp;
    memRsp_t memRsp;

    bundleIssue issueInst (
        .clk(clk),
        .rstn(rstn),
        .bundleValid(bundleValid),
        .bundleReady(bundleReady),
        .bundle(bundle),
        .readIndex(readIndex),
        .readData(readData),
        .slotCmd(slotCmd),
        .slotDone({results[2].done, results[1].done, results[0].done}),
        .commit(commit)
    );

    registerFile regFileInst (
        .clk(clk),
        .rstn(rstn),
        .readIndex(readIndex),
        .readData(readData),
        .results(results),
        .commit(commit)
    );

    aluSlot slot0Alu (
        .clk(clk),
        .rstn(rstn),
        .cmd(slotCmd[0]),
        .result(results[0]),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData),
        .commit(commit)
    );

    memSlot #(.memAddrWidth(memAddrWidth)) slot1Mem (
        .clk(clk),
        .rstn(rstn),
        .cmd(slotCmd[1]),
        .result(results[1]),
        .memReq(slot1Req),
        .memRsp(slot1Rsp),
        .commit(commit)
    );

    memSlot #(.memAddrWidth(memAddrWidth)) slot2Mem (
        .clk(clk),
        .rstn(rstn),
        .cmd(slotCmd[2]),
        .result(results[2]),
        .memReq(slot2Req),
        .memRsp(slot2Rsp),
        .commit(commit)
    );

    // slot 1 on the high priority side
    memArbiter #(.memAddrWidth(memAddrWidth)) arbiterInst (
        .clk(clk),
        .rstn(rstn),
        .req0(slot1Req),
        .rsp0(slot1Rsp),
        .req1(slot2Req),
        .rsp1(slot2Rsp),
        .memReq(memReq),
        .memRsp(memRsp)
    );

    dataMemory #(.memAddrWidth(memAddrWidth)) dataMemInst (
        .clk(clk),
        .req(memReq),
        .rsp(memRsp)
    );

endmodule

// File: vliwCore_tb.sv
`timescale 1ns/1ps

module vliwCore_tb;
    import vliwIsaPkg::*;

    logic                 clk;
    logic                 rstn;
    logic                 bundleValid;
    logic                 bundleReady;
    bundle_t              bundle;
    logic                 outValid;
    logic                 outReady;
    logic [dataWidth-1:0] outData;

    bundle_t              bundles[$];
    logic [dataWidth-1:0] expectedOut[$];
    int                   outCount;
    logic                 dataLoaded;
    logic [31:0]          rngState;

    vliwCore vliwCore_inst (
        .clk(clk),
        .rstn(rstn),
        .bundleValid(bundleValid),
        .bundleReady(bundleReady),
        .bundle(bundle),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expectedValue);
        if (actual !== expectedValue) begin
            stopWithFailure($sformatf("ERROR at time %0t: %s is %08h, expected %08h",
                                      $time, name, actual, expectedValue));
        end
    endtask

    // '#' starts a comment that runs to the end of the line
    task automatic loadTestData();
        int          fd;
        int          c;
        int          count;
        logic [7:0]  ch;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] word;
        fd = $fopen("vliwCore_testdata.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open vliwCore_testdata.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c != -1 && c[7:0] != 8'h0A) begin
                        c = $fgetc(fd);
                    end
                end else if (ch == "B") begin
                    count = $fscanf(fd, "%h %h %h", w2, w1, w0);
                    if (count != 3) begin
                        stopWithFailure("a bundle line in the test data is incomplete");
                    end else begin
                        bundles.push_back({w2, w1, w0});
                    end
                end else if (ch == "E") begin
                    count = $fscanf(fd, "%h", word);
                    if (count != 1) begin
                        stopWithFailure("an expected value line in the test data is broken");
                    end else begin
                        expectedOut.push_back(word);
                    end
                end else if (!(ch inside {8'h20, 8'h09, 8'h0A, 8'h0D})) begin
                    stopWithFailure("the test data holds an unknown line type");
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // holds valid until the core has taken the bundle
    task automatic sendBundle(input bundle_t value);
        logic taken;
        bundleValid = 1'b1;
        bundle = value;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = bundleReady;
            @(posedge clk);
            #1;
        end
        bundleValid = 1'b0;
    endtask

    initial begin
        rstn = 1'b0;
        bundleValid = 1'b0;
        bundle = '0;
        outCount = 0;
        dataLoaded = 1'b0;
        loadTestData();
        dataLoaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        checkValue("bundleReady", 32'(bundleReady), 32'd1);
        checkValue("outValid", 32'(outValid), 32'd0);
        @(posedge clk);
        #1;
        foreach (bundles[i]) begin
            sendBundle(bundles[i]);
        end
        // last bundle is over once the core is ready again
        @(negedge clk);
        while (!bundleReady) begin
            @(negedge clk);
        end
        if (outCount == expectedOut.size()) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stopWithFailure($sformatf("only %0d of %0d expected outputs were seen",
                                      outCount, expectedOut.size()));
        end
    end

    // random back-pressure, handshake sampled mid-cycle
    initial begin
        outReady = 1'b0;
        rngState = 32'ha00b;
        forever begin
            @(posedge clk);
            #1;
            rngState = xorshift32(rngState);
            outReady = rngState[0];
            @(negedge clk);
            if (rstn && outValid && outReady) begin
                if (outCount >= expectedOut.size()) begin
                    stopWithFailure("the core sent more outputs than the test data expects");
                end else begin
                    checkValue("outData", outData, expectedOut[outCount]);
                    outCount++;
                end
            end
        end
    end

    initial begin
        wait (dataLoaded);
        repeat (bundles.size() * 40 + 4) @(posedge clk);
        stopWithFailure("timeout, the bundles did not finish in time");
    end

endmodule

// File: vliwCore.f
vliwIsaPkg.sv
vliwBusPkg.sv
dataMemory.sv
memArbiter.sv
memSlot.sv
aluSlot.sv
registerFile.sv
bundleIssue.sv
vliwCore.sv
vliwCore_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= vliwCore_tb
FILELIST   ?= vliwCore.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall --timing
PASS_TEXT  ?= Done: no errors

SOURCES := $(wildcard *.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: vliwCore_testdata.txt
# B <slot 2 instr> <slot 1 instr> <slot 0 instr>, one bundle, hex words
# E <expected output word>, hex, in the order of the OUT instructions
B 00000000 00000000 1C011234
B 00000000 00000000 2002ABCD
B 00000000 00000000 1C03FFFB
B 00000000 00000000 24200000
E 00001234
B 00000000 00000000 24400000
E ABCD0000
B 00000000 00000000 24600000
E FFFFFFFB
B 00000000 00000000 04222000
B 00000000 00000000 08232800
B 00000000 00000000 0C833000
B 00000000 00000000 10A23800
B 00000000 00000000 14834000
B 00000000 00000000 18254800
B 2C050020 2C040010 24800000
E ABCD1234
B 280B0010 280A0020 24A00000
E 00001239
B 00000000 00000000 24C00000
E ABCD1230
B 00000000 00000000 24E00000
E ABCD1239
B 00000000 00000000 25000000
E 5432EDCF
B 2C690004 00000000 25200000
E 68000000
B 00000000 281000FF 25400000
E 00001239
B 280C0030 2C060030 25600000
E ABCD1234
B 280D0020 280D0010 1C0D7777
B 00000000 280E0030 1C0E5555
B 00000000 00000000 25800000
E ABCD1230
B 00000000 280C0010 042C7800
B 00000000 00000000 25A00000
E 00001239
B 00000000 00000000 25C00000
E ABCD1230
B 00000000 00000000 25E00000
E ABCD2464
B 00000000 00000000 25800000
E ABCD1234
B 00000000 00000000 26000000
E 68000000
